// File: common/triBridgePkg.sv
`default_nettype none

`include "triBridge_macros.svh"

package triBridgePkg;

  // plain vectors with a meaning
  typedef logic [`PADDR_W-1:0] paddrT;
  typedef logic [`IC_INDEX_W-1:0] icIndexT;
  typedef logic [`IC_TAG_W-1:0] icTagT;
  typedef logic [`DC_INDEX_W-1:0] dcIndexT;
  typedef logic [`DC_TAG_W-1:0] dcTagT;
  typedef logic [`IC_LINE_W-1:0] icLineT;
  typedef logic [`DC_LINE_W-1:0] dcLineT;
  typedef logic [`DWORD_W-1:0] dwordT;
  typedef logic [`ST_SIZE_W-1:0] stSizeT;
  typedef logic [`RQTYPE_W-1:0] rqTypeT;
  typedef logic [`RETTYPE_W-1:0] retTypeT;
  typedef logic [`SIZE_CODE_W-1:0] sizeCodeT;

  // block addresses are tag plus index, no line offset
  typedef logic [`IC_TAG_W+`IC_INDEX_W-1:0] icBlkAddrT;
  typedef logic [`DC_TAG_W+`DC_INDEX_W-1:0] dcBlkAddrT;

  // encoding order is also the issue priority
  typedef enum logic [1:0] {
    SRC_ST,
    SRC_LD,
    SRC_IC
  } srcT;

  typedef enum logic {
    REQ_IDLE,
    REQ_WAIT
  } reqStateT;

  // core side miss requests, each val is a one cycle strobe
  typedef struct packed {
    logic icVal;
    icBlkAddrT icBlkAddr;
    logic ldVal;
    dcBlkAddrT ldBlkAddr;
    logic stVal;
    paddrT stAddr;
    dwordT stData;
    stSizeT stSize;
  } coreReqT;

  typedef struct packed {
    rqTypeT rqtype;
    sizeCodeT size;
    paddrT address;
    dwordT data;
  } l15ReqT;

  typedef struct packed {
    logic val;
    retTypeT returntype;
    paddrT address;
    // word 0 sits in the low bits
    dwordT [3:0] data;
    logic invalIcache;
    logic invalDcache;
    logic [`INV_ADDR_HI:`INV_ADDR_LO] invalAddr;
  } l15RespT;

  typedef struct packed {
    logic valid;
    icTagT tag;
    icIndexT index;
    icLineT line;
  } icFillT;

  typedef struct packed {
    logic valid;
    dcTagT tag;
    dcIndexT index;
    dcLineT line;
  } dcFillT;

  // sized for the dcache index, icache only uses the low IC_INDEX_W bits
  typedef struct packed {
    logic valid;
    dcIndexT index;
  } invT;

  // fabric is big endian, swap bytes inside one 64 bit word
  function automatic dwordT swapBytes(input dwordT d);
    dwordT r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = d[8*(7-i) +: 8];
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// File: common/triBridge_macros.svh
`ifndef TRIBRIDGE_MACROS_SVH
`define TRIBRIDGE_MACROS_SVH

// fabric physical address
`define PADDR_W 40
`define DWORD_W 64

// icache geometry, 32 byte lines
`define IC_LINE_BYTES_LOG 5
`define IC_INDEX_W 6
`define IC_TAG_W 29
`define IC_LINE_W (8 << `IC_LINE_BYTES_LOG)

// dcache geometry, 16 byte lines
`define DC_LINE_BYTES_LOG 4
`define DC_INDEX_W 8
`define DC_TAG_W 28
`define DC_LINE_W (8 << `DC_LINE_BYTES_LOG)

// stores allowed in flight before stall
`define ST_CREDITS 2

// field widths on the L1.5 port
`define RQTYPE_W 5
`define RETTYPE_W 4
`define SIZE_CODE_W 3
`define ST_SIZE_W 2

// invalidate address slice carried by the fabric
`define INV_ADDR_HI 15
`define INV_ADDR_LO 4

// request codes
`define RQ_LOAD 5'd0
`define RQ_STORE 5'd1
`define RQ_IMISS 5'd16

// return codes
`define RET_LOAD 4'd0
`define RET_IFILL 4'd1
`define RET_EVICT 4'd3
`define RET_ST_ACK 4'd4
`define RET_INT 4'd7

// size codes, log2 of bytes
`define SZ_1B 3'd0
`define SZ_2B 3'd1
`define SZ_4B 3'd2
`define SZ_8B 3'd3
`define SZ_16B 3'd4
`define SZ_32B 3'd5

`endif

// File: design/triBridge.sv
`timescale 1ns/100ps
`default_nettype none

module triBridge (
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // core side misses
  input  wire triBridgePkg::coreReqT coreReq_i,
  output logic                       stStall_o,

  // L1.5 request port
  output logic                       l15Val_o,
  output triBridgePkg::l15ReqT       l15Req_o,
  input  wire logic                  l15Ack_i,

  // L1.5 return port
  input  wire triBridgePkg::l15RespT l15Resp_i,
  output logic                       l15ReqAck_o,

  // toward the caches and the core
  output triBridgePkg::icFillT       icFill_o,
  output triBridgePkg::dcFillT       dcFill_o,
  output triBridgePkg::invT          icInv_o,
  output triBridgePkg::invT          dcInv_o,
  output logic                       stComplete_o,
  output logic                       coreRst_n_o
);

  import triBridgePkg::*;

  // selected source and captured payloads
  srcT src;
  coreReqT held;

  // store accounting
  logic stIssued;

  reqFsm reqFsmInst (
    .clk        (clk),
    .rst_n      (rst_n),
    .coreReq_i  (coreReq_i),
    .l15Ack_i   (l15Ack_i),
    .src_o      (src),
    .l15Val_o   (l15Val_o),
    .held_o     (held),
    .stIssued_o (stIssued)
  );

  // fields follow the held payload, stable while valid is up
  reqPacker reqPackerInst (
    .src_i    (src),
    .held_i   (held),
    .l15Req_o (l15Req_o)
  );

  // store acks come back as the store complete pulse
  storeCreditCounter storeCreditCounterInst (
    .clk        (clk),
    .rst_n      (rst_n),
    .stIssued_i (stIssued),
    .stAck_i    (stComplete_o),
    .stStall_o  (stStall_o)
  );

  respDecoder respDecoderInst (
    .clk          (clk),
    .rst_n        (rst_n),
    .l15Resp_i    (l15Resp_i),
    .l15ReqAck_o  (l15ReqAck_o),
    .icFill_o     (icFill_o),
    .dcFill_o     (dcFill_o),
    .icInv_o      (icInv_o),
    .dcInv_o      (dcInv_o),
    .stComplete_o (stComplete_o),
    .coreRst_n_o  (coreRst_n_o)
  );

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/triBridgePkg.sv
request/reqFsm.sv
request/reqPacker.sv
request/storeCreditCounter.sv
response/respDecoder.sv
design/triBridge.sv
verification/triBridgeTb.sv

// File: request/reqFsm.sv
`timescale 1ns/100ps
`default_nettype none

module reqFsm (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire triBridgePkg::coreReqT coreReq_i,
  input  wire logic                  l15Ack_i,
  output triBridgePkg::srcT          src_o,
  output logic                       l15Val_o,
  output triBridgePkg::coreReqT      held_o,
  output logic                       stIssued_o
);

  import triBridgePkg::*;

  reqStateT state;
  srcT srcQ;
  srcT srcPick;

  // one bit per source indexed by srcT
  logic [2:0] strobe;
  logic [2:0] pend;
  logic [2:0] done;

  // captured payloads
  icBlkAddrT icAddrQ;
  dcBlkAddrT ldAddrQ;
  paddrT stAddrQ;
  dwordT stDataQ;
  stSizeT stSizeQ;

  // payload of the request on the fabric
  logic [$bits(paddrT)+$bits(dwordT)+$bits(stSizeT)-1:0] busPayload;

  assign strobe[SRC_ST] = coreReq_i.stVal;
  assign strobe[SRC_LD] = coreReq_i.ldVal;
  assign strobe[SRC_IC] = coreReq_i.icVal;

  // fixed priority with store first
  always_comb begin
    if (pend[SRC_ST]) begin
      srcPick = SRC_ST;
    end else if (pend[SRC_LD]) begin
      srcPick = SRC_LD;
    end else begin
      srcPick = SRC_IC;
    end
  end

  // request retires at the edge where ack is seen
  assign done = (state == REQ_WAIT && l15Ack_i) ? (3'b001 << srcQ) : 3'b000;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= REQ_IDLE;
      srcQ <= SRC_ST;
      pend <= 3'b000;
    end else begin
      case (state)
        REQ_IDLE: begin
          if (|pend) begin
            state <= REQ_WAIT;
            srcQ <= srcPick;
          end
        end
        REQ_WAIT: begin
          if (l15Ack_i) begin
            state <= REQ_IDLE;
          end
        end
        default: state <= REQ_IDLE;
      endcase
      // new strobe sets the bit and ack clears it
      pend <= (pend & ~done) | strobe;
    end
  end

  // payload only loads on its own strobe
  always_ff @(posedge clk) begin
    if (strobe[SRC_IC]) begin
      icAddrQ <= coreReq_i.icBlkAddr;
    end
    if (strobe[SRC_LD]) begin
      ldAddrQ <= coreReq_i.ldBlkAddr;
    end
    if (strobe[SRC_ST]) begin
      stAddrQ <= coreReq_i.stAddr;
      stDataQ <= coreReq_i.stData;
      stSizeQ <= coreReq_i.stSize;
    end
  end

  // val fields report what is still pending
  always_comb begin
    held_o.icVal = pend[SRC_IC];
    held_o.icBlkAddr = icAddrQ;
    held_o.ldVal = pend[SRC_LD];
    held_o.ldBlkAddr = ldAddrQ;
    held_o.stVal = pend[SRC_ST];
    held_o.stAddr = stAddrQ;
    held_o.stData = stDataQ;
    held_o.stSize = stSizeQ;
  end

  // selected source payload zero padded
  always_comb begin
    busPayload = '0;
    case (srcQ)
      SRC_ST: busPayload = {stAddrQ, stDataQ, stSizeQ};
      SRC_LD: busPayload[$bits(dcBlkAddrT)-1:0] = ldAddrQ;
      default: busPayload[$bits(icBlkAddrT)-1:0] = icAddrQ;
    endcase
  end

  assign src_o = srcQ;
  assign l15Val_o = (state == REQ_WAIT);
  // credit taken when the core hands the store over
  assign stIssued_o = coreReq_i.stVal;

  // core must wait for its own request to retire
  noStrobeOnPending: assert property (
    @(posedge clk) disable iff (!rst_n) (strobe & pend) == 3'b000
  ) else $error("strobe for a source that is still pending");

  // valid, source and payload stay put until ack
  valHeldToAck: assert property (
    @(posedge clk) disable iff (!rst_n)
    l15Val_o && !l15Ack_i |=> l15Val_o && $stable(srcQ) && $stable(busPayload)
  ) else $error("valid or request fields changed without ack");

endmodule

`default_nettype wire

// File: request/reqPacker.sv
`timescale 1ns/100ps
`default_nettype none

`include "triBridge_macros.svh"

module reqPacker (
  input  wire triBridgePkg::srcT     src_i,
  input  wire triBridgePkg::coreReqT held_i,
  output triBridgePkg::l15ReqT       l15Req_o
);

  import triBridgePkg::*;

  // line aligned addresses
  paddrT icAddr;
  paddrT ldAddr;

  // store payload in fabric byte order
  dwordT stDataBe;

  // block address plus zero line offset
  assign icAddr = {held_i.icBlkAddr, {`IC_LINE_BYTES_LOG{1'b0}}};
  assign ldAddr = {held_i.ldBlkAddr, {`DC_LINE_BYTES_LOG{1'b0}}};

  assign stDataBe = swapBytes(held_i.stData);

  always_comb begin
    case (src_i)
      SRC_ST: begin
        l15Req_o.rqtype = `RQ_STORE;
        // store size is already log2 of bytes
        l15Req_o.size = sizeCodeT'(held_i.stSize);
        // full byte address, no alignment
        l15Req_o.address = held_i.stAddr;
        l15Req_o.data = stDataBe;
      end
      SRC_LD: begin
        // one dcache line
        l15Req_o.rqtype = `RQ_LOAD;
        l15Req_o.size = `SZ_16B;
        l15Req_o.address = ldAddr;
        l15Req_o.data = '0;
      end
      SRC_IC: begin
        // one icache line
        l15Req_o.rqtype = `RQ_IMISS;
        l15Req_o.size = `SZ_32B;
        l15Req_o.address = icAddr;
        l15Req_o.data = '0;
      end
      default: begin
        l15Req_o.rqtype = `RQ_LOAD;
        l15Req_o.size = `SZ_16B;
        l15Req_o.address = ldAddr;
        l15Req_o.data = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: request/storeCreditCounter.sv
`timescale 1ns/100ps
`default_nettype none

`include "triBridge_macros.svh"

module storeCreditCounter (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic stIssued_i,
  input  wire logic stAck_i,
  output logic      stStall_o
);

  localparam int CntW = $clog2(`ST_CREDITS + 1);

  // stores handed to the bridge and not yet acked
  logic [CntW-1:0] count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({stIssued_i, stAck_i})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        // both or neither, net zero
        default: count <= count;
      endcase
    end
  end

  // no reserve, stall right at the limit
  assign stStall_o = (count == CntW'(`ST_CREDITS));

  // core ignored the stall, or fabric acked a store never sent
  creditBounds: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(stIssued_i && !stAck_i && count == CntW'(`ST_CREDITS)) &&
    !(stAck_i && !stIssued_i && count == '0)
  ) else $error("store credit over or underflow");

endmodule

`default_nettype wire

// File: response/respDecoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "triBridge_macros.svh"

module respDecoder (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire triBridgePkg::l15RespT l15Resp_i,
  output logic                       l15ReqAck_o,
  output triBridgePkg::icFillT       icFill_o,
  output triBridgePkg::dcFillT       dcFill_o,
  output triBridgePkg::invT          icInv_o,
  output triBridgePkg::invT          dcInv_o,
  output logic                       stComplete_o,
  output logic                       coreRst_n_o
);

  import triBridgePkg::*;

  // decoded return type
  logic isIfill;
  logic isLoad;
  logic isEvict;
  logic isStAck;
  logic isInt;

  // fill data back in core byte order
  icLineT icLineD;
  dcLineT dcLineD;

  // one cycle pulses and the core run flag
  logic ackQ;
  logic icValQ;
  logic dcValQ;
  logic icInvValQ;
  logic dcInvValQ;
  logic stCompQ;
  logic coreRunQ;

  // payload registers loaded on a matching return
  icTagT icTagQ;
  icIndexT icIdxQ;
  icLineT icLineQ;
  dcTagT dcTagQ;
  dcIndexT dcIdxQ;
  dcLineT dcLineQ;
  dcIndexT icInvIdxQ;
  dcIndexT dcInvIdxQ;

  assign isIfill = l15Resp_i.val && (l15Resp_i.returntype == `RET_IFILL);
  assign isLoad = l15Resp_i.val && (l15Resp_i.returntype == `RET_LOAD);
  assign isEvict = l15Resp_i.val && (l15Resp_i.returntype == `RET_EVICT);
  assign isStAck = l15Resp_i.val && (l15Resp_i.returntype == `RET_ST_ACK);
  assign isInt = l15Resp_i.val && (l15Resp_i.returntype == `RET_INT);

  // icache takes all four words and dcache only words 0 and 1
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      icLineD[`DWORD_W*i +: `DWORD_W] = swapBytes(l15Resp_i.data[i]);
    end
  end
  assign dcLineD = icLineD[`DC_LINE_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ackQ <= 1'b0;
      icValQ <= 1'b0;
      dcValQ <= 1'b0;
      icInvValQ <= 1'b0;
      dcInvValQ <= 1'b0;
      stCompQ <= 1'b0;
      coreRunQ <= 1'b0;
    end else begin
      // every return is acked one cycle later
      ackQ <= l15Resp_i.val;
      icValQ <= isIfill;
      dcValQ <= isLoad;
      icInvValQ <= isEvict && l15Resp_i.invalIcache;
      dcInvValQ <= isEvict && l15Resp_i.invalDcache;
      stCompQ <= isStAck;
      // wakeup releases the core until the next bridge reset
      if (isInt) begin
        coreRunQ <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (isIfill) begin
      icTagQ <= l15Resp_i.address[`PADDR_W-1 -: `IC_TAG_W];
      icIdxQ <= l15Resp_i.address[`IC_LINE_BYTES_LOG +: `IC_INDEX_W];
      icLineQ <= icLineD;
    end
    if (isLoad) begin
      dcTagQ <= l15Resp_i.address[`PADDR_W-1 -: `DC_TAG_W];
      dcIdxQ <= l15Resp_i.address[`DC_LINE_BYTES_LOG +: `DC_INDEX_W];
      dcLineQ <= dcLineD;
    end
    if (isEvict) begin
      // invalAddr keeps address bit numbering and the icache index is zero extended
      icInvIdxQ <= dcIndexT'(l15Resp_i.invalAddr[`IC_LINE_BYTES_LOG +: `IC_INDEX_W]);
      dcInvIdxQ <= l15Resp_i.invalAddr[`DC_LINE_BYTES_LOG +: `DC_INDEX_W];
    end
  end

  assign l15ReqAck_o = ackQ;
  assign icFill_o = '{valid: icValQ, tag: icTagQ, index: icIdxQ, line: icLineQ};
  assign dcFill_o = '{valid: dcValQ, tag: dcTagQ, index: dcIdxQ, line: dcLineQ};
  assign icInv_o = '{valid: icInvValQ, index: icInvIdxQ};
  assign dcInv_o = '{valid: dcInvValQ, index: dcInvIdxQ};
  assign stComplete_o = stCompQ;
  assign coreRst_n_o = coreRunQ;

  // fabric sends only the return types decoded here
  knownReturnType: assert property (
    @(posedge clk) disable iff (!rst_n)
    l15Resp_i.val |-> (isIfill || isLoad || isEvict || isStAck || isInt)
  ) else $error("unsupported return type from the fabric");

endmodule

`default_nettype wire

// File: verification/triBridgeTb.sv
`timescale 1ns/100ps
`default_nettype none

module triBridgeTb;

  import triBridgePkg::*;

  localparam int ClkPeriod = 20;
  localparam int MaxRec = 64;
  localparam int Cols = 10;

  // one parsed trace line, f holds the op specific columns
  typedef struct packed {
    logic [7:0] op;
    logic [15:0] dly;
    logic [7:0][63:0] f;
  } traceRecT;

  logic clk;
  logic rst_n;
  coreReqT coreReq;
  logic stStall;
  logic l15Val;
  l15ReqT l15Req;
  logic l15Ack;
  l15RespT l15Resp;
  logic l15ReqAck;
  icFillT icFill;
  dcFillT dcFill;
  invT icInv;
  invT dcInv;
  logic stComplete;
  logic coreRst_n;

  traceRecT trace [0:MaxRec-1];
  int nRec;
  int errCount;
  logic traceLoaded;

  // response side outputs seen in the cycle after a return
  icFillT icSnap;
  dcFillT dcSnap;
  invT icInvSnap;
  invT dcInvSnap;
  logic stCompSnap;
  logic ackSnap;

  triBridge DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .coreReq_i    (coreReq),
    .stStall_o    (stStall),
    .l15Val_o     (l15Val),
    .l15Req_o     (l15Req),
    .l15Ack_i     (l15Ack),
    .l15Resp_i    (l15Resp),
    .l15ReqAck_o  (l15ReqAck),
    .icFill_o     (icFill),
    .dcFill_o     (dcFill),
    .icInv_o      (icInv),
    .dcInv_o      (dcInv),
    .stComplete_o (stComplete),
    .coreRst_n_o  (coreRst_n)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic reportMismatch(input string msg);
    errCount++;
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic loadTrace;
    int fd;
    int n;
    string lineStr;
    logic [63:0] col [0:Cols-1];
    traceRecT rec;
    fd = $fopen("verification/triBridge_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file verification/triBridge_trace.txt");
      $display("Result: FAILED");
      $fatal(1, "no stimulus");
    end
    nRec = 0;
    while (!$feof(fd)) begin
      lineStr = "";
      n = $fgets(lineStr, fd);
      // skip comments and blank lines
      if (n > 0 && lineStr[0] != "#" && lineStr[0] != "\n") begin
        n = $sscanf(lineStr, "%h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                    col[3], col[4], col[5], col[6], col[7], col[8], col[9]);
        if (n != Cols || col[0] < 1 || col[0] > 5 || nRec == MaxRec) begin
          $display("Malformed or excess trace line: %s", lineStr);
          $display("Result: FAILED");
          $fatal(1, "bad trace");
        end
        rec.op = col[0][7:0];
        rec.dly = col[1][15:0];
        for (int i = 0; i < 8; i++) begin
          rec.f[i] = col[i+2];
        end
        trace[nRec] = rec;
        nRec++;
      end
    end
    $fclose(fd);
  endtask

  // every drive happens 2 ns after the rising edge
  task automatic nextCycle;
    @(posedge clk);
    #2;
  endtask

  // one cycle strobe, mask bit0 ic, bit1 ld, bit2 st
  task automatic driveStrobe(input traceRecT r);
    coreReq.icVal = r.f[0][0];
    coreReq.ldVal = r.f[0][1];
    coreReq.stVal = r.f[0][2];
    coreReq.icBlkAddr = icBlkAddrT'(r.f[1]);
    coreReq.ldBlkAddr = dcBlkAddrT'(r.f[2]);
    coreReq.stAddr = paddrT'(r.f[3]);
    coreReq.stData = r.f[4];
    coreReq.stSize = stSizeT'(r.f[5]);
    nextCycle;
    coreReq.icVal = 1'b0;
    coreReq.ldVal = 1'b0;
    coreReq.stVal = 1'b0;
  endtask

  task automatic driveReturn(input traceRecT r);
    l15Resp.val = 1'b1;
    l15Resp.returntype = retTypeT'(r.f[0]);
    l15Resp.address = paddrT'(r.f[1]);
    for (int i = 0; i < 4; i++) begin
      l15Resp.data[i] = r.f[2+i];
    end
    l15Resp.invalIcache = r.f[6][0];
    l15Resp.invalDcache = r.f[6][1];
    l15Resp.invalAddr = r.f[7][11:0];
    nextCycle;
    l15Resp = '0;
    icSnap = icFill;
    dcSnap = dcFill;
    icInvSnap = icInv;
    dcInvSnap = dcInv;
    stCompSnap = stComplete;
    ackSnap = l15ReqAck;
    assert (ackSnap === 1'b1) else reportMismatch("l15ReqAck_o missing after return");
    // ack is a single cycle pulse
    nextCycle;
    assert (l15ReqAck === 1'b0) else reportMismatch("l15ReqAck_o held past one cycle");
  endtask

  task automatic checkRequestFields(input traceRecT r);
    assert (l15Val === 1'b1) else reportMismatch("l15Val_o dropped before ack");
    assert (l15Req.rqtype === rqTypeT'(r.f[0])) else reportMismatch(
      $sformatf("rqtype %0h, expected %0h", l15Req.rqtype, rqTypeT'(r.f[0])));
    assert (l15Req.size === sizeCodeT'(r.f[1])) else reportMismatch(
      $sformatf("size %0h, expected %0h", l15Req.size, sizeCodeT'(r.f[1])));
    assert (l15Req.address === paddrT'(r.f[2])) else reportMismatch(
      $sformatf("address %h, expected %h", l15Req.address, paddrT'(r.f[2])));
    assert (l15Req.data === r.f[3]) else reportMismatch(
      $sformatf("data %h, expected %h", l15Req.data, r.f[3]));
  endtask

  // fabric model, ack withheld for dly cycles
  task automatic expectRequest(input traceRecT r);
    while (l15Val !== 1'b1) begin
      nextCycle;
    end
    for (int i = 0; i < r.dly; i++) begin
      checkRequestFields(r);
      nextCycle;
    end
    checkRequestFields(r);
    l15Ack = 1'b1;
    nextCycle;
    l15Ack = 1'b0;
    assert (l15Val === 1'b0) else reportMismatch("l15Val_o still high after ack");
  endtask

  // sel 1 icache fill, 2 dcache fill, 3 invalidates, 4 pulse levels
  task automatic checkOutputs(input traceRecT r);
    case (r.f[0])
      1: begin
        assert (icSnap.valid === 1'b1) else reportMismatch("icache fill not valid");
        assert (icSnap.tag === icTagT'(r.f[1]) && icSnap.index === icIndexT'(r.f[2]))
          else reportMismatch($sformatf("icache tag/index %h/%h", icSnap.tag, icSnap.index));
        assert (icSnap.line === {r.f[6], r.f[5], r.f[4], r.f[3]}) else reportMismatch(
          $sformatf("icache line %h", icSnap.line));
      end
      2: begin
        assert (dcSnap.valid === 1'b1) else reportMismatch("dcache fill not valid");
        assert (dcSnap.tag === dcTagT'(r.f[1]) && dcSnap.index === dcIndexT'(r.f[2]))
          else reportMismatch($sformatf("dcache tag/index %h/%h", dcSnap.tag, dcSnap.index));
        assert (dcSnap.line === {r.f[4], r.f[3]}) else reportMismatch(
          $sformatf("dcache line %h", dcSnap.line));
      end
      3: begin
        assert (icInvSnap === {r.f[1][0], dcIndexT'(r.f[2])}) else reportMismatch(
          $sformatf("icache invalidate %h", icInvSnap));
        assert (dcInvSnap === {r.f[3][0], dcIndexT'(r.f[4])}) else reportMismatch(
          $sformatf("dcache invalidate %h", dcInvSnap));
      end
      default: begin
        assert ({stCompSnap, icSnap.valid, dcSnap.valid, icInvSnap.valid, dcInvSnap.valid}
          === {r.f[1][0], r.f[2][0], r.f[3][0], r.f[4][0], r.f[5][0]})
          else reportMismatch($sformatf("pulses stComp/icFill/dcFill/icInv/dcInv %b%b%b%b%b",
            stCompSnap, icSnap.valid, dcSnap.valid, icInvSnap.valid, dcInvSnap.valid));
      end
    endcase
  endtask

  task automatic checkLevels(input traceRecT r);
    assert (stStall === r.f[0][0]) else reportMismatch($sformatf("stStall_o %b", stStall));
    assert (coreRst_n === r.f[1][0]) else reportMismatch(
      $sformatf("coreRst_n_o %b", coreRst_n));
    assert (l15Val === r.f[2][0]) else reportMismatch($sformatf("l15Val_o %b", l15Val));
  endtask

  initial begin
    rst_n = 1'b0;
    coreReq = '0;
    l15Ack = 1'b0;
    l15Resp = '0;
    errCount = 0;
    traceLoaded = 1'b0;
    loadTrace();
    traceLoaded = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int k = 0; k < nRec; k++) begin
      case (trace[k].op)
        1: driveStrobe(trace[k]);
        2: driveReturn(trace[k]);
        3: expectRequest(trace[k]);
        4: checkOutputs(trace[k]);
        default: checkLevels(trace[k]);
      endcase
      // dly is the ack delay for requests, idle cycles otherwise
      if (trace[k].op != 3) begin
        repeat (trace[k].dly) nextCycle;
      end
    end
    if (errCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog, 50 cycles per trace line
  initial begin
    wait (traceLoaded === 1'b1);
    #(nRec * 50 * ClkPeriod);
    $display("Timeout: run exceeded %0d cycles", nRec * 50);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: verification/triBridge_trace.txt
# op dly f0..f7, hex; 1 strobe mask(ic1 ld2 st4) icBlk ldBlk stAddr stData stSize
# 2 return type addr d0..d3 invFlags invAddr[15:4]; 3 request rqtype size addr data
# 4 outputs sel(1 ic 2 dc 3 inv 4 pulses) fields; 5 levels stStall coreRst_n l15Val
5 3 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0
2 0 0 3456789AB0 0123456789ABCDEF FEDCBA9876543210 1111111111111111 2222222222222222 0 0
4 0 2 3456789 AB EFCDAB8967452301 1032547698BADCFE 0 0 0
5 2 0 0 0 0 0 0 0 0
2 0 7 0 0 0 0 0 0 0
4 0 4 0 0 0 0 0 0 0
5 0 0 1 0 0 0 0 0 0
1 0 7 123456789 ABCDEF012 00DEADBEE8 0011223344556677 3 0 0
3 2 1 3 00DEADBEE8 7766554433221100 0 0 0 0
3 0 0 4 ABCDEF0120 0 0 0 0 0
3 3 10 5 2468ACF120 0 0 0 0 0
5 0 0 1 0 0 0 0 0 0
2 0 4 0 0 0 0 0 0 0
4 0 4 1 0 0 0 0 0 0
5 0 0 1 0 0 0 0 0 0
1 0 4 0 0 0000001004 8899AABBCCDDEEFF 2 0 0
3 1 1 2 0000001004 FFEEDDCCBBAA9988 0 0 0 0
5 0 0 1 0 0 0 0 0 0
1 0 4 0 0 7FFFFFFFF1 0102030405060708 0 0 0
5 0 1 1 0 0 0 0 0 0
3 4 1 0 7FFFFFFFF1 0807060504030201 0 0 0 0
5 1 1 1 0 0 0 0 0 0
2 0 4 0 0 0 0 0 0 0
4 0 4 1 0 0 0 0 0 0
5 0 0 1 0 0 0 0 0 0
2 0 4 0 0 0 0 0 0 0
4 0 4 1 0 0 0 0 0 0
5 0 0 1 0 0 0 0 0 0
2 0 1 F0E1D2C3A0 0001020304050607 08090A0B0C0D0E0F 1011121314151617 18191A1B1C1D1E1F 0 0
4 0 1 1E1C3A58 1D 0706050403020100 0F0E0D0C0B0A0908 1716151413121110 1F1E1D1C1B1A1918 0
4 0 4 0 1 0 0 0 0 0
2 0 0 00000FFFF0 CAFEF00DDEADBEEF 5555AAAA3333CCCC 0 0 0 0
4 0 2 FF FF EFBEADDE0DF0FECA CCCC3333AAAA5555 0 0 0
4 0 4 0 0 1 0 0 0 0
2 0 3 0 0 0 0 0 3 B7E
4 0 3 1 3F 1 7E 0 0 0
4 0 4 0 0 0 1 1 0 0
5 2 0 1 0 0 0 0 0 0
